/* Makefile */
TOP := controlUnitTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f files.f -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

/* files.f */
+incdir+logic
logic/cpuControlPkg.sv
logic/stageSequencer.sv
logic/aluFuncDecode.sv
logic/controlSignalGen.sv
logic/controlUnit.sv
test/controlUnitTb.sv

/* logic/aluFuncDecode.sv */
`timescale 1ns/100ps

`include "cpuControl_config.svh"

module aluFuncDecode
    import cpuControlPkg::*;
(
    input  instField_t inst,
    output exCtrl_t    exCtrl
);

    always_comb
    begin
        // unknown codes fall through as a harmless pc + reg add
        exCtrl.aluOp   = ALU_ADD;
        exCtrl.aluSrcA = 1'b0;
        exCtrl.aluSrcB = SRCB_REG;
        exCtrl.immSel  = IMM_SEXT8;

        case (inst.opcode)
            `OP_RTYPE:
            begin
                exCtrl.aluSrcA = 1'b1;
                case (inst.func)
                    `FN_ADD: exCtrl.aluOp = ALU_ADD;
                    `FN_SUB: exCtrl.aluOp = ALU_SUB;
                    `FN_AND: exCtrl.aluOp = ALU_AND;
                    `FN_ORR: exCtrl.aluOp = ALU_ORR;
                    `FN_NOT: exCtrl.aluOp = ALU_NOT;
                    `FN_TCP: exCtrl.aluOp = ALU_TCP;
                    `FN_SHL:
                    begin
                        exCtrl.aluOp   = ALU_SHL;
                        exCtrl.aluSrcB = SRCB_ONE;    // shift by one
                    end
                    `FN_SHR:
                    begin
                        exCtrl.aluOp   = ALU_SHR;
                        exCtrl.aluSrcB = SRCB_ONE;
                    end
                    `FN_JPR, `FN_JRL:
                        exCtrl.aluSrcB = SRCB_ZERO;   // pass rs through as target
                    default: ;
                endcase
            end
            `OP_ADI, `OP_LWD, `OP_SWD:
            begin
                exCtrl.aluSrcA = 1'b1;
                exCtrl.aluSrcB = SRCB_IMM;           // base plus signed offset
            end
            `OP_ORI:
            begin
                exCtrl.aluOp   = ALU_ORR;
                exCtrl.aluSrcA = 1'b1;
                exCtrl.aluSrcB = SRCB_IMM;
                exCtrl.immSel  = IMM_ZEXT8;
            end
            `OP_LHI:
            begin
                exCtrl.aluOp   = ALU_LHI;
                exCtrl.aluSrcA = 1'b1;
                exCtrl.aluSrcB = SRCB_IMM;
                exCtrl.immSel  = IMM_ZEXT8;
            end
            `OP_BNE, `OP_BEQ:
            begin
                exCtrl.aluOp   = (inst.opcode == `OP_BNE) ? ALU_BNE : ALU_BEQ;
                exCtrl.aluSrcA = 1'b1;
            end
            `OP_BGZ, `OP_BLZ:
            begin
                exCtrl.aluOp   = (inst.opcode == `OP_BGZ) ? ALU_BGZ : ALU_BLZ;
                exCtrl.aluSrcA = 1'b1;
                exCtrl.aluSrcB = SRCB_ZERO;          // sign test against zero
            end
            `OP_JMP, `OP_JAL:
            begin
                exCtrl.aluSrcB = SRCB_IMM;
                exCtrl.immSel  = IMM_TARGET12;       // target from pc and 12-bit field
            end
            default: ;
        endcase
    end

endmodule

/* logic/controlSignalGen.sv */
`timescale 1ns/100ps

`include "cpuControl_config.svh"

module controlSignalGen
    import cpuControlPkg::*;
(
    input  stage_t       stage,
    input  instField_t   inst,
    input  exCtrl_t      exCtrl,
    output ctrlSignals_t ctrl
);

    always_comb
    begin
        ctrl = '0;
        case (stage)
            IF1, IF2:
                ctrl.memRead = 1'b1;
            IF3:
            begin
                ctrl.memRead = 1'b1;
                ctrl.irWrite = 1'b1;            // latch the fetched word
            end
            IF4:
            begin
                ctrl.pcWrite = 1'b1;            // pc + 1
                ctrl.aluOp   = ALU_ADD;
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = SRCB_ONE;
            end
            ID:
            begin
                // speculative branch target
                ctrl.aluOp       = ALU_ADD;
                ctrl.aluSrcA     = 1'b0;
                ctrl.aluSrcB     = SRCB_IMM;
                ctrl.immSel      = IMM_SEXT8;
                ctrl.aluOutWrite = 1'b1;
            end
            EX1:
            begin
                ctrl.aluOp       = exCtrl.aluOp;
                ctrl.aluSrcA     = exCtrl.aluSrcA;
                ctrl.aluSrcB     = exCtrl.aluSrcB;
                ctrl.immSel      = exCtrl.immSel;
                ctrl.aluOutWrite = 1'b1;
            end
            EX2:
            begin
                if (isBranch(inst))
                begin
                    // compare held on the alu, taken target from aluOut
                    ctrl.aluOp       = exCtrl.aluOp;
                    ctrl.aluSrcA     = exCtrl.aluSrcA;
                    ctrl.aluSrcB     = exCtrl.aluSrcB;
                    ctrl.immSel      = exCtrl.immSel;
                    ctrl.pcWriteCond = 1'b1;
                    ctrl.pcSource    = 1'b1;
                end
                else if (isJump(inst))
                begin
                    ctrl.pcWrite  = 1'b1;
                    ctrl.pcSource = 1'b1;
                end
            end
            MEM1, MEM2, MEM3, MEM4:
            begin
                ctrl.iorD = 1'b1;               // address from aluOut
                if (isLoad(inst))
                begin
                    ctrl.memRead  = 1'b1;
                    ctrl.mdrWrite = (stage == MEM4);
                end
                if (isStore(inst))
                    ctrl.memWrite = (stage == MEM2);
            end
            WB:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = isLoad(inst);
                if (isLink(inst))
                    ctrl.regDst = DST_LINK;
                else if (inst.opcode == `OP_RTYPE)
                    ctrl.regDst = DST_RD;       // R-type
                else
                    ctrl.regDst = DST_RT;
            end
            default: ;                          // HALT drives nothing
        endcase
    end

endmodule

/* logic/controlUnit.sv */
`timescale 1ns/100ps

module controlUnit
    import cpuControlPkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  instField_t   inst,
    output ctrlSignals_t ctrl,
    output logic         halted
);

    stage_t  stage;
    exCtrl_t exCtrl;

    stageSequencer sequencer (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .stage  (stage),
        .halted (halted)
    );

    aluFuncDecode exDecode (
        .inst   (inst),
        .exCtrl (exCtrl)
    );

    controlSignalGen signalGen (
        .stage  (stage),
        .inst   (inst),
        .exCtrl (exCtrl),
        .ctrl   (ctrl)
    );

endmodule

/* logic/cpuControlPkg.sv */
`include "cpuControl_config.svh"

package cpuControlPkg;

    typedef enum logic [3:0] {
        IF1, IF2, IF3, IF4,
        ID,
        EX1, EX2,
        MEM1, MEM2, MEM3, MEM4,
        WB,
        HALT
    } stage_t;

    typedef enum logic [`ALU_FUNC_WIDTH-1:0] {
        ALU_ADD = `ALUFN_ADD,
        ALU_SUB = `ALUFN_SUB,
        ALU_AND = `ALUFN_AND,
        ALU_ORR = `ALUFN_ORR,
        ALU_NOT = `ALUFN_NOT,
        ALU_TCP = `ALUFN_TCP,
        ALU_SHL = `ALUFN_SHL,
        ALU_SHR = `ALUFN_SHR,
        ALU_LHI = `ALUFN_LHI,
        ALU_BNE = `ALUFN_BNE,
        ALU_BEQ = `ALUFN_BEQ,
        ALU_BGZ = `ALUFN_BGZ,
        ALU_BLZ = `ALUFN_BLZ
    } aluFunc_t;

    typedef enum logic [1:0] {SRCB_REG, SRCB_ONE, SRCB_IMM, SRCB_ZERO} aluSrcB_t;
    typedef enum logic [1:0] {IMM_SEXT8, IMM_ZEXT8, IMM_TARGET12} immSel_t;
    typedef enum logic [1:0] {DST_RT, DST_RD, DST_LINK} regDst_t;

    typedef struct packed {
        logic [`OPCODE_WIDTH-1:0] opcode;
        logic [`FUNC_WIDTH-1:0]   func;
    } instField_t;

    typedef struct packed {
        logic     pcWriteCond;
        logic     pcWrite;
        logic     iorD;          // 1 selects aluOut as memory address
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        logic     irWrite;
        logic     pcSource;      // 0 alu result, 1 aluOut
        aluFunc_t aluOp;
        logic     aluSrcA;       // 0 pc, 1 register A
        aluSrcB_t aluSrcB;
        immSel_t  immSel;
        logic     regWrite;
        regDst_t  regDst;
        logic     aluOutWrite;
        logic     mdrWrite;
    } ctrlSignals_t;

    typedef struct packed {
        aluFunc_t aluOp;
        logic     aluSrcA;
        aluSrcB_t aluSrcB;
        immSel_t  immSel;
    } exCtrl_t;

    function automatic logic isLoad(instField_t inst);
        return inst.opcode == `OP_LWD;
    endfunction

    function automatic logic isStore(instField_t inst);
        return inst.opcode == `OP_SWD;
    endfunction

    function automatic logic isBranch(instField_t inst);
        return inst.opcode inside {`OP_BNE, `OP_BEQ, `OP_BGZ, `OP_BLZ};
    endfunction

    function automatic logic isJump(instField_t inst);
        logic regJump;
        regJump = (inst.opcode == `OP_RTYPE) && (inst.func inside {`FN_JPR, `FN_JRL});
        return regJump || (inst.opcode inside {`OP_JMP, `OP_JAL});
    endfunction

    // jumps that save the return address in r2
    function automatic logic isLink(instField_t inst);
        logic regLink;
        regLink = (inst.opcode == `OP_RTYPE) && (inst.func == `FN_JRL);
        return regLink || (inst.opcode == `OP_JAL);
    endfunction

    function automatic logic writesBack(instField_t inst);
        logic rtypeAlu;
        rtypeAlu = (inst.opcode == `OP_RTYPE) && (inst.func inside {`FN_ADD, `FN_SUB,
            `FN_AND, `FN_ORR, `FN_NOT, `FN_TCP, `FN_SHL, `FN_SHR});
        return rtypeAlu || isLink(inst) || (inst.opcode inside {`OP_ADI, `OP_ORI, `OP_LHI});
    endfunction

    function automatic logic isHalt(instField_t inst);
        return (inst.opcode == `OP_RTYPE) && (inst.func == `FN_HLT);
    endfunction

endpackage

/* logic/cpuControl_config.svh */
`ifndef CPU_CONTROL_CONFIG_SVH
`define CPU_CONTROL_CONFIG_SVH

`define OPCODE_WIDTH    4
`define FUNC_WIDTH      6
`define ALU_FUNC_WIDTH  4

// opcode field
`define OP_BNE    4'd0
`define OP_BEQ    4'd1
`define OP_BGZ    4'd2
`define OP_BLZ    4'd3
`define OP_ADI    4'd4
`define OP_ORI    4'd5
`define OP_LHI    4'd6
`define OP_LWD    4'd7
`define OP_SWD    4'd8
`define OP_JMP    4'd9
`define OP_JAL    4'd10
`define OP_RTYPE  4'd15

// function field, R-type only
`define FN_ADD    6'd0
`define FN_SUB    6'd1
`define FN_AND    6'd2
`define FN_ORR    6'd3
`define FN_NOT    6'd4
`define FN_TCP    6'd5
`define FN_SHL    6'd6
`define FN_SHR    6'd7
`define FN_JPR    6'd25
`define FN_JRL    6'd26
`define FN_HLT    6'd29

// ALU operation codes
`define ALUFN_ADD  4'd0
`define ALUFN_SUB  4'd1
`define ALUFN_AND  4'd2
`define ALUFN_ORR  4'd3
`define ALUFN_NOT  4'd4
`define ALUFN_TCP  4'd5
`define ALUFN_SHL  4'd6
`define ALUFN_SHR  4'd7
`define ALUFN_LHI  4'd8
`define ALUFN_BNE  4'd9
`define ALUFN_BEQ  4'd10
`define ALUFN_BGZ  4'd11
`define ALUFN_BLZ  4'd12

`endif

/* logic/stageSequencer.sv */
`timescale 1ns/100ps

module stageSequencer
    import cpuControlPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  instField_t inst,
    output stage_t     stage,
    output logic       halted
);

    stage_t nextStage;

    always_comb
    begin
        nextStage = stage;
        case (stage)
            IF1:  nextStage = IF2;
            IF2:  nextStage = IF3;
            IF3:  nextStage = IF4;
            IF4:  nextStage = ID;
            ID:   nextStage = EX1;
            EX1:  nextStage = EX2;
            EX2:
            begin
                if (isLoad(inst) || isStore(inst))
                    nextStage = MEM1;
                else if (writesBack(inst))
                    nextStage = WB;
                else if (isHalt(inst))
                    nextStage = HALT;
                else
                    nextStage = IF1;    // branches, JMP, JPR, NOPs
            end
            MEM1: nextStage = MEM2;
            MEM2: nextStage = MEM3;
            MEM3: nextStage = MEM4;
            MEM4:
            begin
                if (isLoad(inst))
                    nextStage = WB;
                else
                    nextStage = IF1;
            end
            WB:   nextStage = IF1;
            HALT: nextStage = HALT;     // parked until reset
            default: nextStage = IF1;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            stage <= IF1;
        else
            stage <= nextStage;
    end

    assign halted = (stage == HALT);

endmodule

/* test/controlStimulus.txt */
// hex columns: opcode func length aluOp memWrite regWrite pcWriteCond regDst memToReg
// regDst 0 rt, 1 rd, 2 link; length in cycles from one IF1 to the next
f 00 08 0 0 1 0 1 0
f 01 08 1 0 1 0 1 0
f 02 08 2 0 1 0 1 0
f 03 08 3 0 1 0 1 0
f 04 08 4 0 1 0 1 0
f 05 08 5 0 1 0 1 0
f 06 08 6 0 1 0 1 0
f 07 08 7 0 1 0 1 0
f 1a 08 0 0 1 0 2 0
f 19 07 0 0 0 0 0 0
4 00 08 0 0 1 0 0 0
5 2c 08 3 0 1 0 0 0
6 11 08 8 0 1 0 0 0
7 05 0c 0 0 1 0 0 1
8 3f 0b 0 1 0 0 0 0
0 21 07 9 0 0 1 0 0
1 00 07 a 0 0 1 0 0
2 0e 07 b 0 0 1 0 0
3 30 07 c 0 0 1 0 0
9 15 07 0 0 0 0 0 0
a 02 08 0 0 1 0 2 0
7 3a 0c 0 0 1 0 0 1
f 14 07 0 0 0 0 0 0
f 1c 07 0 0 0 0 0 0
b 00 07 0 0 0 0 0 0
f 1d 07 0 0 0 0 0 0

/* test/controlUnitTb.sv */
`timescale 1ns/100ps

`include "cpuControl_config.svh"

module controlUnitTb
    import cpuControlPkg::*;
;

    localparam int DRIVE_DELAY = 10;
    localparam int FIELDS      = 9;     // columns per stimulus line
    localparam int MAX_TESTS   = 32;

    logic         clk;
    logic         reset;
    instField_t   inst;
    ctrlSignals_t ctrl;
    logic         halted;

    logic [7:0] stim [0:FIELDS*MAX_TESTS-1];
    int testCount;
    int testsRun;
    int failedTests;
    int testErrors;
    int timeLimit;
    logic parked;

    controlUnit UUT (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .ctrl   (ctrl),
        .halted (halted)
    );

    always #50 clk = ~clk;

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (actual == expected)
        else
        begin
            $display("Fail at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            testErrors++;
        end
    endtask

    task automatic reportTest(input string label);
        testsRun++;
        if (testErrors != 0)
            failedTests++;
        $display("%s: %s", label, (testErrors == 0) ? "ok" : "FAILED");
    endtask

    // after reset only memRead, and the fetch latches in the third cycle
    task automatic checkReset;
        ctrlSignals_t expected;
        int cycles;
        expected = '0;
        expected.memRead = 1'b1;
        testErrors = 0;
        @(negedge clk);
        checkValue("ctrl", int'(expected), int'(ctrl));
        checkValue("halted", 0, int'(halted));
        cycles = 0;
        while (!ctrl.irWrite)
        begin
            @(negedge clk);
            cycles++;
        end
        checkValue("irWrite cycle", 2, cycles);
        reportTest("reset");
    endtask

    // entered at the IF3 sample; counts from IF4 up to the next IF3 or HALT
    task automatic runTest(input int idx);
        int base;
        int expLen;
        int cycles;
        int outPulses;
        int memWrites;
        int regWrites;
        int condWrites;
        int pcWrites;
        int aluOpSeen;
        int dstSeen;
        int m2rSeen;
        logic expectHalt;
        logic jumpInst;
        logic done;
        base = idx * FIELDS;
        testErrors = 0;
        cycles = 0;
        outPulses = 0;
        memWrites = 0;
        regWrites = 0;
        condWrites = 0;
        pcWrites = 0;
        aluOpSeen = -1;
        dstSeen = -1;
        m2rSeen = -1;
        done = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
        inst.opcode = stim[base][3:0];
        inst.func   = stim[base+1][5:0];
        expectHalt  = (inst.opcode == `OP_RTYPE) && (inst.func == `FN_HLT);
        // jumps load the pc a second time in EX2
        jumpInst    = (inst.opcode inside {`OP_JMP, `OP_JAL})
            || ((inst.opcode == `OP_RTYPE) && (inst.func inside {`FN_JPR, `FN_JRL}));
        while (!done)
        begin
            @(negedge clk);
            cycles++;
            if (cycles == 1)
                checkValue("IF4 pcWrite", 1, int'(ctrl.pcWrite && !ctrl.pcSource));
            if (ctrl.aluOutWrite)
            begin
                outPulses++;
                if (outPulses == 2)
                    aluOpSeen = int'(ctrl.aluOp);   // EX1
            end
            if (ctrl.memWrite)
                memWrites++;
            if (ctrl.pcWriteCond)
                condWrites++;
            if (ctrl.pcWrite)
                pcWrites++;
            if (ctrl.regWrite)
            begin
                regWrites++;
                dstSeen = int'(ctrl.regDst);
                m2rSeen = int'(ctrl.memToReg);
            end
            if (ctrl.irWrite || halted)
                done = 1'b1;
        end
        // HALT sits where the next IF1 would be, two cycles before its IF3
        expLen = expectHalt ? int'(stim[base+2]) - 2 : int'(stim[base+2]);
        checkValue("halted", int'(expectHalt), int'(halted));
        checkValue("length", expLen, cycles);
        checkValue("aluOp", int'(stim[base+3]), aluOpSeen);
        checkValue("memWrite count", int'(stim[base+4]), memWrites);
        checkValue("regWrite count", int'(stim[base+5]), regWrites);
        checkValue("pcWriteCond count", int'(stim[base+6]), condWrites);
        checkValue("pcWrite count", jumpInst ? 2 : 1, pcWrites);
        if (stim[base+5] != 8'h0)
        begin
            checkValue("regDst", int'(stim[base+7]), dstSeen);
            checkValue("memToReg", int'(stim[base+8]), m2rSeen);
        end
        if (expectHalt)
        begin
            repeat (10)
            begin
                @(negedge clk);
                checkValue("halted", 1, int'(halted));
                checkValue("ctrl", 0, int'(ctrl));
            end
            parked = 1'b1;
        end
        reportTest($sformatf("test %0d op %h fn %h", idx, inst.opcode, inst.func));
    endtask

    initial
    begin
        int sumLen;
        clk = 1'b0;
        reset = 1'b1;
        inst = '0;
        testsRun = 0;
        failedTests = 0;
        testErrors = 0;
        parked = 1'b0;
        timeLimit = 0;
        for (int i = 0; i < FIELDS * MAX_TESTS; i++)
            stim[i] = 8'hff;                        // end marker
        $readmemh("test/controlStimulus.txt", stim);
        testCount = 0;
        sumLen = 0;
        while (testCount < MAX_TESTS && stim[testCount * FIELDS] != 8'hff)
        begin
            sumLen += int'(stim[testCount * FIELDS + 2]);
            testCount++;
        end
        timeLimit = (sumLen + 50) * 100;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        checkReset();
        for (int i = 0; i < testCount && !parked; i++)
            runTest(i);
        $display("%0d tests run, %0d failed", testsRun, failedTests);
        if (failedTests == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

    initial
    begin
        wait (timeLimit != 0);
        #(timeLimit);
        $display("Timeout: the run did not finish within %0d ns", timeLimit);
        $display("Some tests failed");
        $finish;
    end

endmodule
